// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    // kept major opcodes of rv32i
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    // add is the zero encoding so a cleared control word is harmless
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_pass_b = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {op1_rs1, op1_pc, op1_zero} op1_sel_e;
    typedef enum logic {op2_rs2, op2_imm} op2_sel_e;
    typedef enum logic [1:0] {wb_alu, wb_pc_plus4, wb_mem} wb_sel_e;
    typedef enum logic [1:0] {fwd_none, fwd_exe, fwd_mem, fwd_wb} fwd_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      is_beq;
        logic      is_bne;
        logic      is_jal;
        wb_sel_e   wb_sel;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rd;
    } ex_ctrl_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        wb_sel_e   wb_sel;
        reg_addr_t rd;
    } mem_ctrl_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
    } wb_ctrl_t;

endpackage

// File: hdl/stage_reg.sv
module stage_reg #(
    parameter type payload_t = rv_pkg::word_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // a cleared control payload is a bubble
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// File: hdl/reg_file.sv
module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    input  rv_pkg::reg_addr_t dbg_reg,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    output rv_pkg::word_t     dbg_data
);

    // x0 has no storage
    rv_pkg::word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // no write-through, writeback forwarding handles that case
    assign rdata1   = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2   = (raddr2 == '0) ? '0 : regs[raddr2];
    assign dbg_data = (dbg_reg == '0) ? '0 : regs[dbg_reg];

    // data landing in a real register is always known
    assert property (@(posedge clk) disable iff (!rst_n)
        (we && waddr != '0) |-> !$isunknown(wdata))
        else $error("unknown data written to register x%0d", waddr);

endmodule

// File: hdl/rv_decoder.sv
module rv_decoder (
    input  rv_pkg::word_t    instr,
    output rv_pkg::ex_ctrl_t ctrl,
    output rv_pkg::op1_sel_e op1_sel,
    output rv_pkg::op2_sel_e op2_sel,
    output rv_pkg::word_t    imm
);

    rv_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    rv_pkg::alu_op_e alu_fn;
    logic            alu_ok;

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // shared funct3 map for register and immediate arithmetic
    always_comb begin
        alu_ok = 1'b1;
        case (funct3)
            3'b000: alu_fn = (opcode == rv_pkg::opc_op && funct7[5]) ? rv_pkg::alu_sub
                                                                      : rv_pkg::alu_add;
            3'b111: alu_fn = rv_pkg::alu_and;
            3'b110: alu_fn = rv_pkg::alu_or;
            3'b100: alu_fn = rv_pkg::alu_xor;
            default: begin
                alu_fn = rv_pkg::alu_add;
                alu_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl    = '0;
        op1_sel = rv_pkg::op1_rs1;
        op2_sel = rv_pkg::op2_rs2;
        imm     = '0;
        case (opcode)
            rv_pkg::opc_op: begin
                if (alu_ok) begin
                    ctrl.alu_op    = alu_fn;
                    ctrl.reg_write = 1'b1;
                    ctrl.rd        = instr[11:7];
                end
            end
            rv_pkg::opc_op_imm: begin
                if (alu_ok) begin
                    ctrl.alu_op    = alu_fn;
                    ctrl.reg_write = 1'b1;
                    ctrl.rd        = instr[11:7];
                    op2_sel        = rv_pkg::op2_imm;
                    imm            = {{20{instr[31]}}, instr[31:20]};
                end
            end
            rv_pkg::opc_lui: begin
                ctrl.alu_op    = rv_pkg::alu_pass_b;
                ctrl.reg_write = 1'b1;
                ctrl.rd        = instr[11:7];
                op1_sel        = rv_pkg::op1_zero;
                op2_sel        = rv_pkg::op2_imm;
                imm            = {instr[31:12], 12'b0};
            end
            rv_pkg::opc_load: begin
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_mem;
                ctrl.rd        = instr[11:7];
                op2_sel        = rv_pkg::op2_imm;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            rv_pkg::opc_store: begin
                ctrl.mem_write = 1'b1;
                op2_sel        = rv_pkg::op2_imm;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_pkg::opc_branch: begin
                // only beq and bne survive
                ctrl.is_beq = (funct3 == 3'b000);
                ctrl.is_bne = (funct3 == 3'b001);
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_pkg::opc_jal: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_pc_plus4;
                ctrl.rd        = instr[11:7];
                op1_sel        = rv_pkg::op1_pc;
                op2_sel        = rv_pkg::op2_imm;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: hdl/hazard_unit.sv
module hazard_unit (
    input  rv_pkg::word_t     if_instr,
    input  rv_pkg::word_t     dec_instr,
    input  rv_pkg::ex_ctrl_t  dec_ctrl,
    input  rv_pkg::ex_ctrl_t  exe_ctrl,
    input  rv_pkg::mem_ctrl_t mem_ctrl,
    input  rv_pkg::wb_ctrl_t  wb_ctrl,
    input  logic              redirect,
    output logic              pc_write,
    output logic              if_kill,
    output logic              dec_kill,
    output rv_pkg::fwd_sel_e  fwd1,
    output rv_pkg::fwd_sel_e  fwd2
);

    logic load_use;

    // youngest producer wins, x0 never forwards
    function automatic rv_pkg::fwd_sel_e pick_src(input rv_pkg::reg_addr_t rs);
        if (exe_ctrl.reg_write && exe_ctrl.rd != '0 && exe_ctrl.rd == rs) begin
            return rv_pkg::fwd_exe;
        end
        if (mem_ctrl.reg_write && mem_ctrl.rd != '0 && mem_ctrl.rd == rs) begin
            return rv_pkg::fwd_mem;
        end
        if (wb_ctrl.reg_write && wb_ctrl.rd != '0 && wb_ctrl.rd == rs) begin
            return rv_pkg::fwd_wb;
        end
        return rv_pkg::fwd_none;
    endfunction

    assign fwd1 = pick_src(dec_instr[19:15]);
    assign fwd2 = pick_src(dec_instr[24:20]);

    // load in decode feeding the word being fetched
    assign load_use = dec_ctrl.mem_read && dec_ctrl.rd != '0 &&
                      (dec_ctrl.rd == if_instr[19:15] || dec_ctrl.rd == if_instr[24:20]);

    always_comb begin
        pc_write = 1'b1;
        if_kill  = 1'b0;
        dec_kill = 1'b0;
        if (redirect) begin
            if_kill  = 1'b1;
            dec_kill = 1'b1;
        end else if (load_use) begin
            pc_write = 1'b0;
            if_kill  = 1'b1;
        end
    end

    // the load-use bubble keeps a load in execute away from its consumer
    always_comb begin
        assert (!(exe_ctrl.mem_read &&
                  (fwd1 == rv_pkg::fwd_exe || fwd2 == rv_pkg::fwd_exe)))
            else $error("load address forwarded from execute in place of load data");
    end

endmodule

// File: hdl/fetch_stage.sv
module fetch_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pc_write,
    input  logic          if_kill,
    input  logic          redirect,
    input  rv_pkg::word_t target,
    input  rv_pkg::word_t instruction,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t dec_pc,
    output rv_pkg::word_t dec_instr
);

    rv_pkg::word_t pc_next;
    rv_pkg::word_t fetched;

    assign pc_next = redirect ? target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_write) begin
            pc <= pc_next;
        end
    end

    // killed fetch turns into a nop in decode
    assign fetched = if_kill ? rv_pkg::nop_instr : instruction;

    stage_reg u_dec_pc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (if_kill),
        .d     (pc),
        .q     (dec_pc)
    );

    stage_reg u_dec_instr (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (1'b0),
        .d     (fetched),
        .q     (dec_instr)
    );

endmodule

// File: hdl/execute_stage.sv
module execute_stage (
    input  rv_pkg::ex_ctrl_t ctrl,
    input  rv_pkg::word_t    exe_pc,
    input  rv_pkg::word_t    op1,
    input  rv_pkg::word_t    op2,
    input  rv_pkg::word_t    rs1_val,
    input  rv_pkg::word_t    rs2_val,
    input  rv_pkg::word_t    imm,
    output rv_pkg::word_t    result,
    output logic             redirect,
    output rv_pkg::word_t    target
);

    rv_pkg::word_t alu_out;
    rv_pkg::word_t link;
    logic          rs_equal;

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_add: begin
                alu_out = op1 + op2;
            end
            rv_pkg::alu_sub: begin
                alu_out = op1 - op2;
            end
            rv_pkg::alu_and: begin
                alu_out = op1 & op2;
            end
            rv_pkg::alu_or: begin
                alu_out = op1 | op2;
            end
            rv_pkg::alu_xor: begin
                alu_out = op1 ^ op2;
            end
            rv_pkg::alu_pass_b: begin
                alu_out = op2;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    // compare uses the forwarded register values, not the alu operands
    assign rs_equal = (rs1_val == rs2_val);

    assign redirect = (ctrl.is_beq && rs_equal) ||
                      (ctrl.is_bne && !rs_equal) ||
                      ctrl.is_jal;

    // pc-relative target for both branches and jal
    assign target = exe_pc + imm;
    assign link   = exe_pc + 32'd4;

    // loads pick their data later in the memory stage
    assign result = (ctrl.wb_sel == rv_pkg::wb_pc_plus4) ? link : alu_out;

endmodule

// File: hdl/rv_core.sv
module rv_core (
    input  logic              clk,
    input  logic              rst_n,
    output rv_pkg::word_t     pc,
    input  rv_pkg::word_t     instruction,
    output rv_pkg::word_t     mem_addr,
    output rv_pkg::word_t     mem_wdata,
    output logic              mem_read,
    output logic              mem_write,
    input  rv_pkg::word_t     mem_rdata,
    input  rv_pkg::reg_addr_t dbg_reg,
    output rv_pkg::word_t     dbg_data
);

    logic pc_write, if_kill, dec_kill, redirect;
    rv_pkg::fwd_sel_e  fwd1, fwd2;
    rv_pkg::op1_sel_e  op1_sel;
    rv_pkg::op2_sel_e  op2_sel;
    rv_pkg::ex_ctrl_t  dec_ctrl, dec_ctrl_in, exe_ctrl;
    rv_pkg::mem_ctrl_t mem_ctrl_d, mem_ctrl;
    rv_pkg::wb_ctrl_t  wb_ctrl_d, wb_ctrl;
    rv_pkg::word_t dec_pc, dec_instr, dec_imm, rf_rs1, rf_rs2, target;
    rv_pkg::word_t rs1_fwd, rs2_fwd, dec_op1, dec_op2;
    rv_pkg::word_t exe_pc, exe_op1, exe_op2, exe_rs1, exe_rs2, exe_imm, exe_result;
    rv_pkg::word_t mem_result, mem_store, mem_wb_val, wb_data;

    // pick the youngest in-flight value over the register file read
    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_e sel,
                                              input rv_pkg::word_t rf_val);
        case (sel)
            rv_pkg::fwd_exe: return exe_result;
            rv_pkg::fwd_mem: return mem_wb_val;
            rv_pkg::fwd_wb:  return wb_data;
            default:         return rf_val;
        endcase
    endfunction

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .pc_write(pc_write), .if_kill(if_kill),
        .redirect(redirect), .target(target), .instruction(instruction),
        .pc(pc), .dec_pc(dec_pc), .dec_instr(dec_instr)
    );

    rv_decoder u_decoder (
        .instr(dec_instr), .ctrl(dec_ctrl), .op1_sel(op1_sel), .op2_sel(op2_sel), .imm(dec_imm)
    );

    hazard_unit u_hazard (
        .if_instr(instruction), .dec_instr(dec_instr), .dec_ctrl(dec_ctrl),
        .exe_ctrl(exe_ctrl), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl), .redirect(redirect),
        .pc_write(pc_write), .if_kill(if_kill), .dec_kill(dec_kill), .fwd1(fwd1), .fwd2(fwd2)
    );

    reg_file u_regs (
        .clk(clk), .rst_n(rst_n), .we(wb_ctrl.reg_write), .waddr(wb_ctrl.rd),
        .raddr1(dec_instr[19:15]), .raddr2(dec_instr[24:20]), .dbg_reg(dbg_reg),
        .wdata(wb_data), .rdata1(rf_rs1), .rdata2(rf_rs2), .dbg_data(dbg_data)
    );

    // forwarding sits in front of the operand muxes
    assign rs1_fwd = fwd_mux(fwd1, rf_rs1);
    assign rs2_fwd = fwd_mux(fwd2, rf_rs2);
    assign dec_op1 = (op1_sel == rv_pkg::op1_pc)   ? dec_pc :
                     (op1_sel == rv_pkg::op1_zero) ? '0 : rs1_fwd;
    assign dec_op2 = (op2_sel == rv_pkg::op2_imm) ? dec_imm : rs2_fwd;
    assign dec_ctrl_in = dec_kill ? '0 : dec_ctrl;

    // decode to execute
    stage_reg #(.payload_t(rv_pkg::ex_ctrl_t)) u_exe_ctrl (
        .clk(clk), .rst_n(rst_n), .clear(1'b0), .d(dec_ctrl_in), .q(exe_ctrl)
    );
    stage_reg u_exe_pc (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(dec_pc), .q(exe_pc));
    stage_reg u_exe_op1 (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(dec_op1), .q(exe_op1));
    stage_reg u_exe_op2 (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(dec_op2), .q(exe_op2));
    stage_reg u_exe_rs1 (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(rs1_fwd), .q(exe_rs1));
    stage_reg u_exe_rs2 (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(rs2_fwd), .q(exe_rs2));
    stage_reg u_exe_imm (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(dec_imm), .q(exe_imm));

    execute_stage u_execute (
        .ctrl(exe_ctrl), .exe_pc(exe_pc), .op1(exe_op1), .op2(exe_op2), .rs1_val(exe_rs1),
        .rs2_val(exe_rs2), .imm(exe_imm), .result(exe_result), .redirect(redirect),
        .target(target)
    );

    // execute to memory
    assign mem_ctrl_d = '{mem_read: exe_ctrl.mem_read, mem_write: exe_ctrl.mem_write,
                          reg_write: exe_ctrl.reg_write, wb_sel: exe_ctrl.wb_sel,
                          rd: exe_ctrl.rd};
    stage_reg #(.payload_t(rv_pkg::mem_ctrl_t)) u_mem_ctrl (
        .clk(clk), .rst_n(rst_n), .clear(1'b0), .d(mem_ctrl_d), .q(mem_ctrl)
    );
    stage_reg u_mem_res (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(exe_result), .q(mem_result));
    stage_reg u_mem_st (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(exe_rs2), .q(mem_store));

    assign mem_addr   = mem_result;
    assign mem_wdata  = mem_store;
    assign mem_read   = mem_ctrl.mem_read;
    assign mem_write  = mem_ctrl.mem_write;
    assign mem_wb_val = (mem_ctrl.wb_sel == rv_pkg::wb_mem) ? mem_rdata : mem_result;

    // memory to writeback
    assign wb_ctrl_d = '{reg_write: mem_ctrl.reg_write, rd: mem_ctrl.rd};
    stage_reg #(.payload_t(rv_pkg::wb_ctrl_t)) u_wb_ctrl (
        .clk(clk), .rst_n(rst_n), .clear(1'b0), .d(wb_ctrl_d), .q(wb_ctrl)
    );
    stage_reg u_wb_data (.clk(clk), .rst_n(rst_n), .clear(1'b0), .d(mem_wb_val), .q(wb_data));

    // a taken redirect leaves a bubble in execute on the next cycle
    assert property (@(posedge clk) disable iff (!rst_n) redirect |=> (exe_ctrl == '0))
        else $error("instruction survived a taken redirect");

endmodule

// File: verif/tb_rv_core.sv
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int prog_len   = 40;
    localparam int rom_words  = 64;
    localparam int ram_words  = 64;
    localparam int timeout_ns = prog_len * 4 * 4 + 400;
    localparam rv_pkg::word_t final_pc = 32'((prog_len - 1) * 4);

    typedef struct packed {
        rv_pkg::word_t addr;
        rv_pkg::word_t data;
    } store_t;

    logic              clk = 1'b0;
    logic              rst_n;
    rv_pkg::word_t     pc, instruction, mem_addr, mem_wdata, mem_rdata, dbg_data;
    logic              mem_read, mem_write;
    rv_pkg::reg_addr_t dbg_reg;

    rv_pkg::word_t rom [rom_words];
    rv_pkg::word_t ram [ram_words];
    rv_pkg::word_t exp_regs [32];
    store_t        exp_stores [$];
    store_t        want;
    integer        seed;
    int            st_idx = 0;
    int            st_errs = 0;
    int            errs = 0;

    rv_core uut (
        .clk(clk), .rst_n(rst_n), .pc(pc), .instruction(instruction),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_read(mem_read),
        .mem_write(mem_write), .mem_rdata(mem_rdata), .dbg_reg(dbg_reg), .dbg_data(dbg_data)
    );

    always #2 clk = ~clk;

    // both memories answer in the same cycle
    assign instruction = rom[pc[7:2]];
    assign mem_rdata   = ram[mem_addr[7:2]];

    function automatic rv_pkg::word_t fill_word(input int idx);
        rv_pkg::word_t a;
        a = 32'(idx) << 2;
        return (a * 32'h0001_0003) ^ 32'ha5a5_0000;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < ram_words; i++) begin
                ram[i] <= fill_word(i);
            end
        end else if (mem_write) begin
            ram[mem_addr[7:2]] <= mem_wdata;
        end
    end

    // instruction encoders
    function automatic rv_pkg::word_t r_type(input int f7, f3, rd, rs1, rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), rv_pkg::opc_op};
    endfunction

    function automatic rv_pkg::word_t i_type(input rv_pkg::opcode_e opc,
                                             input int f3, rd, rs1, imm);
        return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic rv_pkg::word_t s_type(input int rs2, rs1, imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_pkg::opc_store};
    endfunction

    function automatic rv_pkg::word_t b_type(input int f3, rs1, rs2, off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'(f3), off[4:1], off[11],
                rv_pkg::opc_branch};
    endfunction

    function automatic rv_pkg::word_t u_type(input int rd, imm);
        return {imm[19:0], 5'(rd), rv_pkg::opc_lui};
    endfunction

    function automatic rv_pkg::word_t j_type(input int rd, off);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), rv_pkg::opc_jal};
    endfunction

    // word offset from the x10 base, keeps the address inside the ram
    function automatic int mem_off();
        return (($random(seed) & 63) * 4) - 64;
    endfunction

    function automatic void build_program();
        int off_a, off_b, off_c, off_d, off_e;
        off_a = mem_off();
        off_b = mem_off();
        off_c = mem_off();
        off_d = mem_off();
        off_e = mem_off();
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = rv_pkg::nop_instr;
        end
        // dependent alu chain
        rom[0]  = u_type(1, $random(seed));
        rom[1]  = i_type(rv_pkg::opc_op_imm, 0, 1, 1, $random(seed));
        rom[2]  = i_type(rv_pkg::opc_op_imm, 0, 2, 0, $random(seed));
        rom[3]  = r_type(0, 0, 3, 1, 2);
        rom[4]  = r_type(32, 0, 4, 3, 1);
        rom[5]  = r_type(0, 4, 5, 4, 3);
        rom[6]  = r_type(0, 7, 6, 5, 1);
        rom[7]  = r_type(0, 6, 7, 6, 2);
        rom[8]  = i_type(rv_pkg::opc_op_imm, 0, 10, 0, 64);
        // stores then load-use pairs
        rom[9]  = s_type(3, 10, off_a);
        rom[10] = s_type(7, 10, off_b);
        rom[11] = i_type(rv_pkg::opc_load, 2, 8, 10, off_a);
        rom[12] = r_type(0, 0, 9, 8, 1);
        rom[13] = i_type(rv_pkg::opc_load, 2, 11, 10, off_c);
        rom[14] = i_type(rv_pkg::opc_op_imm, 4, 12, 11, $random(seed));
        rom[15] = i_type(rv_pkg::opc_op_imm, 7, 13, 12, $random(seed));
        rom[16] = i_type(rv_pkg::opc_op_imm, 6, 14, 13, $random(seed));
        // always taken, 18 and 19 are on the flushed path
        rom[17] = b_type(0, 1, 1, 12);
        rom[18] = s_type(14, 10, off_b);
        rom[19] = i_type(rv_pkg::opc_op_imm, 0, 15, 0, 1);
        rom[20] = b_type(1, 2, 2, 8);
        rom[21] = i_type(rv_pkg::opc_op_imm, 0, 15, 14, $random(seed));
        // data dependent outcomes
        rom[22] = b_type(0, 3, 4, 8);
        rom[23] = s_type(15, 10, off_d);
        rom[24] = b_type(1, 5, 6, 8);
        rom[25] = i_type(rv_pkg::opc_op_imm, 0, 16, 0, $random(seed));
        rom[26] = j_type(17, 12);
        rom[27] = s_type(16, 10, off_a);
        rom[28] = i_type(rv_pkg::opc_op_imm, 0, 18, 0, -1);
        rom[29] = r_type(0, 0, 18, 17, 16);
        rom[30] = i_type(rv_pkg::opc_load, 2, 19, 10, off_d);
        rom[31] = s_type(19, 10, off_c);
        rom[32] = u_type(20, $random(seed));
        rom[33] = r_type(32, 0, 21, 20, 18);
        rom[34] = s_type(21, 10, off_e);
        rom[35] = i_type(rv_pkg::opc_load, 2, 22, 10, off_e);
        rom[36] = r_type(0, 4, 23, 22, 21);
        rom[37] = i_type(rv_pkg::opc_op_imm, 0, 24, 23, $random(seed));
        rom[38] = r_type(0, 6, 25, 24, 9);
        rom[39] = j_type(0, 0);
    endfunction

    // architectural model, one instruction per step, no pipeline
    function automatic bit run_iss();
        rv_pkg::word_t mem [ram_words];
        rv_pkg::word_t x [32];
        rv_pkg::word_t ir, pc_i, next, a, b, res;
        bit            wr;
        int            steps;
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc_i  = '0;
        steps = 0;
        while (pc_i != final_pc && steps < 1000) begin
            ir   = rom[pc_i[7:2]];
            a    = x[ir[19:15]];
            b    = x[ir[24:20]];
            next = pc_i + 32'd4;
            res  = '0;
            wr   = 1'b1;
            case (ir[6:0])
                rv_pkg::opc_op, rv_pkg::opc_op_imm: begin
                    // opcode bit 5 separates register from immediate operand
                    if (!ir[5]) begin
                        b = {{20{ir[31]}}, ir[31:20]};
                    end
                    case (ir[14:12])
                        3'b111:  res = a & b;
                        3'b110:  res = a | b;
                        3'b100:  res = a ^ b;
                        default: res = (ir[5] && ir[30]) ? a - b : a + b;
                    endcase
                end
                rv_pkg::opc_lui: res = {ir[31:12], 12'b0};
                rv_pkg::opc_load: begin
                    res = a + {{20{ir[31]}}, ir[31:20]};
                    res = mem[res[7:2]];
                end
                rv_pkg::opc_store: begin
                    wr = 1'b0;
                    a  = a + {{20{ir[31]}}, ir[31:25], ir[11:7]};
                    mem[a[7:2]] = b;
                    exp_stores.push_back('{addr: a, data: b});
                end
                rv_pkg::opc_branch: begin
                    wr = 1'b0;
                    // funct3 bit 0 inverts the equality test
                    if (ir[12] ^ (a == b)) begin
                        next = pc_i + {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
                    end
                end
                rv_pkg::opc_jal: begin
                    res  = pc_i + 32'd4;
                    next = pc_i + {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && ir[11:7] != 5'd0) begin
                x[ir[11:7]] = res;
            end
            pc_i  = next;
            steps = steps + 1;
        end
        exp_regs = x;
        return pc_i == final_pc;
    endfunction

    task automatic show_mismatch(input string name, input rv_pkg::word_t got,
                                 input rv_pkg::word_t exp);
        $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
    endtask

    // stores are compared in program order
    always @(negedge clk) begin
        if (rst_n && mem_write) begin
            assert (st_idx < exp_stores.size()) else begin
                st_errs++;
                $display("a store to %h at %0t ns was not expected", mem_addr, $time);
            end
            if (st_idx < exp_stores.size()) begin
                want = exp_stores[st_idx];
                assert (mem_addr == want.addr) else begin
                    st_errs++;
                    show_mismatch("mem_addr", mem_addr, want.addr);
                end
                assert (mem_wdata == want.data) else begin
                    st_errs++;
                    show_mismatch("mem_wdata", mem_wdata, want.data);
                end
            end
            st_idx++;
        end
    end

    initial begin
        seed    = 32'haa0d;
        rst_n   = 1'b0;
        dbg_reg = '0;
        build_program();
        assert (run_iss()) else begin
            errs++;
            $display("the reference model never reached the final loop");
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // first cycle out of reset
        assert (pc == '0) else begin
            errs++;
            show_mismatch("pc", pc, '0);
        end
        assert (!mem_read && !mem_write) else begin
            errs++;
            $display("a memory strobe is active in the first cycle after reset");
        end
        while (pc != final_pc) begin
            @(negedge clk);
        end
        // the last instruction before the loop retires within four cycles
        repeat (6) @(negedge clk);
        assert (st_idx == exp_stores.size()) else begin
            errs++;
            $display("%0d stores seen but %0d expected", st_idx, exp_stores.size());
        end
        // debug index set on one falling edge, read back on the next
        for (int r = 0; r < 32; r++) begin
            dbg_reg = 5'(r);
            @(negedge clk);
            assert (dbg_data == exp_regs[r]) else begin
                errs++;
                show_mismatch($sformatf("dbg_data x%0d", r), dbg_data, exp_regs[r]);
            end
        end
        $display("store errors %0d, other errors %0d", st_errs, errs);
        if (st_errs + errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired before the program reached its final loop");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sim.f
hdl/rv_pkg.sv
hdl/stage_reg.sv
hdl/reg_file.sv
hdl/rv_decoder.sv
hdl/hazard_unit.sv
hdl/fetch_stage.sv
hdl/execute_stage.sv
hdl/rv_core.sv
verif/tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
